//--- common/vec_dpath_pkg.sv
/*
  Shared types of the vector datapath: the lane word, the operand and load
  selects, the ALU functions and the per-instruction control struct.
*/

package vec_dpath_pkg;

  // ------------------------------------------------------------
  // Basic sizes
  // ------------------------------------------------------------

  // Width of the element index that comes with each instruction
  localparam int IDX_W = 4;

  // Bytes per word, the step between strided elements
  localparam int WORD_BYTES = 4;

  // One lane word
  typedef logic [31:0] word_t;

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------

  // ALU functions, shared by every lane
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    AND   = 4'd2,
    OR    = 4'd3,
    XOR   = 4'd4,
    SLT   = 4'd5,
    SLTU  = 4'd6,
    SLL   = 4'd7,
    SRL   = 4'd8,
    SRA   = 4'd9,
    PASS1 = 4'd10
  } alu_fn_t;

  // Operand 0 source
  typedef enum logic [1:0] {
    OP0_VEC   = 2'd0,
    OP0_BCAST = 2'd1,
    OP0_ZERO  = 2'd2
  } op0_sel_t;

  // Operand 1 source
  typedef enum logic [1:0] {
    OP1_VEC    = 2'd0,
    OP1_STRIDE = 2'd1,
    OP1_ZERO   = 2'd2
  } op1_sel_t;

  // Subword load adjustment
  typedef enum logic [2:0] {
    LD_W  = 3'd0,
    LD_B  = 3'd1,
    LD_BU = 3'd2,
    LD_H  = 3'd3,
    LD_HU = 3'd4
  } load_kind_t;

  // Decoded controls, enter at D and travel with the data
  typedef struct packed {
    op0_sel_t   op0_sel;
    op1_sel_t   op1_sel;
    alu_fn_t    alu_fn;
    load_kind_t load_kind;
    logic       wb_sel;     // 1 takes the load result at M
  } vec_ctrl_t;

endpackage

//--- verilog/stage_reg.sv
/*
  One pipeline stage register for any payload type. Loads when stall is low
  and holds otherwise; only the valid bit is cleared by reset.
*/
`timescale 1ns/1ps

module stage_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic reset,
  input  logic stall,
  input  logic in_valid,
  input  T     in,
  output logic out_valid,
  output T     out
);

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (!stall) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      out <= in;
    end
  end

endmodule

//--- verilog/operand_select.sv
/*
  D-stage operand selection for every lane. Picks operand 0, operand 1 and
  the store data from vector values, the scalar broadcast or stride offsets.
*/
`timescale 1ns/1ps

module operand_select #(
  parameter int NUM_LANES = 4
) (
  input  vec_dpath_pkg::vec_ctrl_t            ctrl,
  input  vec_dpath_pkg::word_t                v_rdata0 [NUM_LANES],
  input  vec_dpath_pkg::word_t                v_rdata1 [NUM_LANES],
  input  vec_dpath_pkg::word_t                s_rdata0,
  input  logic [vec_dpath_pkg::IDX_W-1:0]     v_idx,
  output vec_dpath_pkg::word_t                op0 [NUM_LANES],
  output vec_dpath_pkg::word_t                op1 [NUM_LANES],
  output vec_dpath_pkg::word_t                wdata [NUM_LANES]
);

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    vec_dpath_pkg::word_t stride;

    // Byte offset of this lane's element, one word per lane past v_idx
    assign stride = 32'(v_idx) * 32'(vec_dpath_pkg::WORD_BYTES)
                  + 32'(k) * 32'(vec_dpath_pkg::WORD_BYTES);

    always_comb begin
      case (ctrl.op0_sel)
        vec_dpath_pkg::OP0_VEC:   op0[k] = v_rdata0[k];
        vec_dpath_pkg::OP0_BCAST: op0[k] = s_rdata0;
        default:                  op0[k] = '0;
      endcase
    end

    always_comb begin
      case (ctrl.op1_sel)
        vec_dpath_pkg::OP1_VEC:    op1[k] = v_rdata1[k];
        vec_dpath_pkg::OP1_STRIDE: op1[k] = stride;
        default:                   op1[k] = '0;
      endcase
    end

    // Stores always write the second vector source
    assign wdata[k] = v_rdata1[k];
  end

endmodule

//--- execute/lane_alu.sv
/*
  32-bit ALU of a single vector lane. Purely combinational, covers every
  function of the ALU function enum.
*/
`timescale 1ns/1ps

module lane_alu (
  input  vec_dpath_pkg::alu_fn_t fn,
  input  vec_dpath_pkg::word_t   in0,
  input  vec_dpath_pkg::word_t   in1,
  output vec_dpath_pkg::word_t   out
);

  logic [4:0] shamt;

  // Shifts only look at the low five bits
  assign shamt = in1[4:0];

  always_comb begin
    case (fn)
      vec_dpath_pkg::ADD:   out = in0 + in1;
      vec_dpath_pkg::SUB:   out = in0 - in1;
      vec_dpath_pkg::AND:   out = in0 & in1;
      vec_dpath_pkg::OR:    out = in0 | in1;
      vec_dpath_pkg::XOR:   out = in0 ^ in1;
      // Set-less-than yields 1 or 0
      vec_dpath_pkg::SLT:   out = {31'b0, $signed(in0) < $signed(in1)};
      vec_dpath_pkg::SLTU:  out = {31'b0, in0 < in1};
      vec_dpath_pkg::SLL:   out = in0 << shamt;
      vec_dpath_pkg::SRL:   out = in0 >> shamt;
      vec_dpath_pkg::SRA:   out = $signed(in0) >>> shamt;
      vec_dpath_pkg::PASS1: out = in1;
      default:              out = '0;
    endcase
  end

endmodule

//--- execute/exec_stage.sv
/*
  X stage of the vector datapath. One ALU per lane, all running the same
  function; the result also serves as the lane's memory address.
*/
`timescale 1ns/1ps

module exec_stage #(
  parameter int NUM_LANES = 4
) (
  input  vec_dpath_pkg::alu_fn_t alu_fn,
  input  vec_dpath_pkg::word_t   op0 [NUM_LANES],
  input  vec_dpath_pkg::word_t   op1 [NUM_LANES],
  output vec_dpath_pkg::word_t   result [NUM_LANES]
);

  // ------------------------------------------------------------
  // Lane ALUs
  // ------------------------------------------------------------

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    // Lanes move in lockstep, one function for all
    lane_alu u_lane_alu (
      .fn  (alu_fn),
      .in0 (op0[k]),
      .in1 (op1[k]),
      .out (result[k])
    );
  end

endmodule

//--- verilog/mem_stage.sv
/*
  M stage of the vector datapath. Sign or zero extends the low byte or half
  of each lane's memory response, then picks the load or the ALU result.
*/
`timescale 1ns/1ps

module mem_stage #(
  parameter int NUM_LANES = 4
) (
  input  vec_dpath_pkg::load_kind_t load_kind,
  input  logic                      wb_sel,
  input  vec_dpath_pkg::word_t      alu_result [NUM_LANES],
  input  vec_dpath_pkg::word_t      dmem_rdata [NUM_LANES],
  output vec_dpath_pkg::word_t      wb_result [NUM_LANES]
);

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    vec_dpath_pkg::word_t load_data;

    // ------------------------------------------------------------
    // Subword adjustment
    // ------------------------------------------------------------

    always_comb begin
      case (load_kind)
        vec_dpath_pkg::LD_W: begin
          load_data = dmem_rdata[k];
        end
        vec_dpath_pkg::LD_B: begin
          load_data = {{24{dmem_rdata[k][7]}}, dmem_rdata[k][7:0]};
        end
        vec_dpath_pkg::LD_BU: begin
          load_data = {24'b0, dmem_rdata[k][7:0]};
        end
        vec_dpath_pkg::LD_H: begin
          load_data = {{16{dmem_rdata[k][15]}}, dmem_rdata[k][15:0]};
        end
        vec_dpath_pkg::LD_HU: begin
          load_data = {16'b0, dmem_rdata[k][15:0]};
        end
        default: begin
          load_data = dmem_rdata[k];
        end
      endcase
    end

    // Writeback select
    assign wb_result[k] = wb_sel ? load_data : alu_result[k];
  end

endmodule

//--- verilog/vec_dpath.sv
/*
  Vector datapath top. Chains the D, X, M, X2, X3 and W stages of all lanes;
  controls enter at D with the operands and results leave at W.
*/
`timescale 1ns/1ps

module vec_dpath #(
  parameter int NUM_LANES = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                stall,
  input  logic                                issue,
  input  vec_dpath_pkg::vec_ctrl_t            ctrl,
  input  vec_dpath_pkg::word_t                v_rdata0 [NUM_LANES],
  input  vec_dpath_pkg::word_t                v_rdata1 [NUM_LANES],
  input  vec_dpath_pkg::word_t                s_rdata0,
  input  logic [vec_dpath_pkg::IDX_W-1:0]     v_idx,
  input  vec_dpath_pkg::word_t                dmem_rdata [NUM_LANES],
  output vec_dpath_pkg::word_t                dmem_addr [NUM_LANES],
  output vec_dpath_pkg::word_t                dmem_wdata [NUM_LANES],
  output logic                                wb_valid,
  output vec_dpath_pkg::word_t                wb_data [NUM_LANES]
);

  typedef vec_dpath_pkg::word_t [NUM_LANES-1:0] lanes_t;

  // Operands and store data, captured into X
  typedef struct packed {
    vec_dpath_pkg::alu_fn_t    alu_fn;
    vec_dpath_pkg::load_kind_t load_kind;
    logic                      wb_sel;
    lanes_t                    op0;
    lanes_t                    op1;
    lanes_t                    wdata;
  } x_pay_t;

  // ALU results and what the load path still needs
  typedef struct packed {
    vec_dpath_pkg::load_kind_t load_kind;
    logic                      wb_sel;
    lanes_t                    alu_result;
  } m_pay_t;

  vec_dpath_pkg::word_t op0_d [NUM_LANES];
  vec_dpath_pkg::word_t op1_d [NUM_LANES];
  vec_dpath_pkg::word_t wdata_d [NUM_LANES];
  vec_dpath_pkg::word_t op0_x [NUM_LANES];
  vec_dpath_pkg::word_t op1_x [NUM_LANES];
  vec_dpath_pkg::word_t result_x [NUM_LANES];
  vec_dpath_pkg::word_t alu_m [NUM_LANES];
  vec_dpath_pkg::word_t wb_m [NUM_LANES];

  x_pay_t x_d, x_q;
  m_pay_t m_d, m_q;
  lanes_t x2_d, x2_q, x3_q, w_q;
  logic   x_valid, m_valid, x2_valid, x3_valid;

  // ------------------------------------------------------------
  // D stage
  // ------------------------------------------------------------

  operand_select #(.NUM_LANES(NUM_LANES)) u_operand_select (
    .ctrl     (ctrl),
    .v_rdata0 (v_rdata0),
    .v_rdata1 (v_rdata1),
    .s_rdata0 (s_rdata0),
    .v_idx    (v_idx),
    .op0      (op0_d),
    .op1      (op1_d),
    .wdata    (wdata_d)
  );

  always_comb begin
    x_d.alu_fn    = ctrl.alu_fn;
    x_d.load_kind = ctrl.load_kind;
    x_d.wb_sel    = ctrl.wb_sel;
    for (int k = 0; k < NUM_LANES; k++) begin
      x_d.op0[k]   = op0_d[k];
      x_d.op1[k]   = op1_d[k];
      x_d.wdata[k] = wdata_d[k];
    end
  end

  stage_reg #(.T(x_pay_t)) u_x_reg (
    .clk (clk), .reset (reset), .stall (stall),
    .in_valid (issue), .in (x_d), .out_valid (x_valid), .out (x_q)
  );

  // ------------------------------------------------------------
  // X stage, memory request goes out here
  // ------------------------------------------------------------

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      op0_x[k]      = x_q.op0[k];
      op1_x[k]      = x_q.op1[k];
      dmem_wdata[k] = x_q.wdata[k];
    end
  end

  exec_stage #(.NUM_LANES(NUM_LANES)) u_exec_stage (
    .alu_fn (x_q.alu_fn),
    .op0    (op0_x),
    .op1    (op1_x),
    .result (result_x)
  );

  always_comb begin
    m_d.load_kind = x_q.load_kind;
    m_d.wb_sel    = x_q.wb_sel;
    for (int k = 0; k < NUM_LANES; k++) begin
      dmem_addr[k]         = result_x[k];
      m_d.alu_result[k]    = result_x[k];
    end
  end

  stage_reg #(.T(m_pay_t)) u_m_reg (
    .clk (clk), .reset (reset), .stall (stall),
    .in_valid (x_valid), .in (m_d), .out_valid (m_valid), .out (m_q)
  );

  // ------------------------------------------------------------
  // M stage, then two delay stages to W
  // ------------------------------------------------------------

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      alu_m[k] = m_q.alu_result[k];
      x2_d[k]  = wb_m[k];
    end
  end

  mem_stage #(.NUM_LANES(NUM_LANES)) u_mem_stage (
    .load_kind  (m_q.load_kind),
    .wb_sel     (m_q.wb_sel),
    .alu_result (alu_m),
    .dmem_rdata (dmem_rdata),
    .wb_result  (wb_m)
  );

  stage_reg #(.T(lanes_t)) u_x2_reg (
    .clk (clk), .reset (reset), .stall (stall),
    .in_valid (m_valid), .in (x2_d), .out_valid (x2_valid), .out (x2_q)
  );

  stage_reg #(.T(lanes_t)) u_x3_reg (
    .clk (clk), .reset (reset), .stall (stall),
    .in_valid (x2_valid), .in (x2_q), .out_valid (x3_valid), .out (x3_q)
  );

  stage_reg #(.T(lanes_t)) u_w_reg (
    .clk (clk), .reset (reset), .stall (stall),
    .in_valid (x3_valid), .in (x3_q), .out_valid (wb_valid), .out (w_q)
  );

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      wb_data[k] = w_q[k];
    end
  end

endmodule

//--- testbench/tb_clock.sv
/*
  Clock and reset source for the testbench. Free-running clock, reset held
  high for the first rising edges and then released.
*/
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- testbench/tb_model.svh
/*
  Testbench models, included inside the testbench top: LFSR step, memory
  contents and the expected address and writeback word of one lane.
*/
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] step_lfsr(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// Memory word, every address bit matters
function automatic vec_dpath_pkg::word_t mem_word(input vec_dpath_pkg::word_t addr);
  return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
endfunction

// Operand choice and ALU of one lane; this is also the lane's address
function automatic vec_dpath_pkg::word_t lane_addr(
  input vec_dpath_pkg::vec_ctrl_t c,
  input vec_dpath_pkg::word_t v0,
  input vec_dpath_pkg::word_t v1,
  input vec_dpath_pkg::word_t s0,
  input logic [vec_dpath_pkg::IDX_W-1:0] idx,
  input int lane
);
  vec_dpath_pkg::word_t a;
  vec_dpath_pkg::word_t b;
  a = (c.op0_sel == vec_dpath_pkg::OP0_VEC) ? v0 :
      (c.op0_sel == vec_dpath_pkg::OP0_BCAST) ? s0 : 32'd0;
  b = (c.op1_sel == vec_dpath_pkg::OP1_VEC) ? v1 :
      (c.op1_sel == vec_dpath_pkg::OP1_STRIDE) ?
        (32'(idx) + 32'(lane)) * 32'(vec_dpath_pkg::WORD_BYTES) : 32'd0;
  case (c.alu_fn)
    vec_dpath_pkg::ADD:   return a + b;
    vec_dpath_pkg::SUB:   return a - b;
    vec_dpath_pkg::AND:   return a & b;
    vec_dpath_pkg::OR:    return a | b;
    vec_dpath_pkg::XOR:   return a ^ b;
    vec_dpath_pkg::SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    vec_dpath_pkg::SLTU:  return (a < b) ? 32'd1 : 32'd0;
    vec_dpath_pkg::SLL:   return a << b[4:0];
    vec_dpath_pkg::SRL:   return a >> b[4:0];
    vec_dpath_pkg::SRA:   return 32'($signed(a) >>> b[4:0]);
    vec_dpath_pkg::PASS1: return b;
    default:              return 32'd0;
  endcase
endfunction

// Writeback word of one lane, ALU result or extended load
function automatic vec_dpath_pkg::word_t lane_result(
  input vec_dpath_pkg::vec_ctrl_t c,
  input vec_dpath_pkg::word_t v0,
  input vec_dpath_pkg::word_t v1,
  input vec_dpath_pkg::word_t s0,
  input logic [vec_dpath_pkg::IDX_W-1:0] idx,
  input int lane
);
  vec_dpath_pkg::word_t r;
  vec_dpath_pkg::word_t m;
  r = lane_addr(c, v0, v1, s0, idx, lane);
  m = mem_word(r);
  if (!c.wb_sel) begin
    return r;
  end
  case (c.load_kind)
    vec_dpath_pkg::LD_B:  return 32'($signed(m[7:0]));
    vec_dpath_pkg::LD_BU: return 32'(m[7:0]);
    vec_dpath_pkg::LD_H:  return 32'($signed(m[15:0]));
    vec_dpath_pkg::LD_HU: return 32'(m[15:0]);
    default:              return m;
  endcase
endfunction

`endif

//--- testbench/tb_vec_dpath.sv
/*
  Testbench top for the vector datapath. Streams vector work through the DUT
  and checks requests and writeback against a five-deep model pipeline.
*/
`timescale 1ns/1ps

module tb_vec_dpath;

  localparam int NUM_LANES  = 4;
  localparam int DEPTH      = 5;
  localparam int WAIT_LIMIT = 200;

  logic clk;
  logic reset;
  logic stall;
  logic issue;
  logic wb_valid;
  vec_dpath_pkg::vec_ctrl_t ctrl;
  vec_dpath_pkg::word_t v_rdata0 [NUM_LANES];
  vec_dpath_pkg::word_t v_rdata1 [NUM_LANES];
  vec_dpath_pkg::word_t s_rdata0;
  logic [vec_dpath_pkg::IDX_W-1:0] v_idx;
  vec_dpath_pkg::word_t dmem_rdata [NUM_LANES];
  vec_dpath_pkg::word_t dmem_addr [NUM_LANES];
  vec_dpath_pkg::word_t dmem_wdata [NUM_LANES];
  vec_dpath_pkg::word_t wb_data [NUM_LANES];
  vec_dpath_pkg::word_t addr_q [NUM_LANES];

  // Model pipeline, entry 0 is X and the last entry is W
  logic model_v [DEPTH];
  vec_dpath_pkg::word_t [NUM_LANES-1:0] model_d [DEPTH];
  vec_dpath_pkg::word_t x_addr [NUM_LANES];
  vec_dpath_pkg::word_t x_wdata [NUM_LANES];

  logic [31:0] lfsr;
  logic stall_on;
  logic hung;
  int errors = 0;
  int checks = 0;
  int results = 0;
  int seq_errors;
  int tests;
  int issued;

  `include "tb_model.svh"

  tb_clock u_clock (.clk(clk), .reset(reset));

  vec_dpath #(.NUM_LANES(NUM_LANES)) dut (
    .clk(clk), .reset(reset), .stall(stall), .issue(issue), .ctrl(ctrl),
    .v_rdata0(v_rdata0), .v_rdata1(v_rdata1), .s_rdata0(s_rdata0), .v_idx(v_idx),
    .dmem_rdata(dmem_rdata), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .wb_valid(wb_valid), .wb_data(wb_data)
  );

  // Memory answers in M for the address sent from X
  always @(posedge clk) begin
    if (!stall) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        addr_q[k] <= dmem_addr[k];
      end
    end
  end

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_mem
    assign dmem_rdata[k] = mem_word(addr_q[k]);
  end

  // ------------------------------------------------------------
  // Compare against the model, then advance it
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        model_v[i] <= 1'b0;
      end
    end else begin
      checks++;
      assert (wb_valid === model_v[DEPTH-1]) else begin
        $display("Error: wb_valid got %h expected %h", wb_valid, model_v[DEPTH-1]);
        errors++;
      end
      for (int k = 0; k < NUM_LANES; k++) begin
        if (model_v[0]) begin
          checks += 2;
          assert (dmem_addr[k] === x_addr[k]) else begin
            $display("Error: dmem_addr[%0d] got %h expected %h", k, dmem_addr[k], x_addr[k]);
            errors++;
          end
          assert (dmem_wdata[k] === x_wdata[k]) else begin
            $display("Error: dmem_wdata[%0d] got %h expected %h", k, dmem_wdata[k],
                     x_wdata[k]);
            errors++;
          end
        end
        if (model_v[DEPTH-1]) begin
          checks++;
          assert (wb_data[k] === model_d[DEPTH-1][k]) else begin
            $display("Error: wb_data[%0d] got %h expected %h", k, wb_data[k],
                     model_d[DEPTH-1][k]);
            errors++;
          end
        end
      end
      if (!stall) begin
        if (wb_valid) begin
          results++;
        end
        model_v[0] <= issue;
        for (int i = 1; i < DEPTH; i++) begin
          model_v[i] <= model_v[i-1];
          model_d[i] <= model_d[i-1];
        end
        for (int k = 0; k < NUM_LANES; k++) begin
          model_d[0][k] <= lane_result(ctrl, v_rdata0[k], v_rdata1[k], s_rdata0, v_idx, k);
          x_addr[k]     <= lane_addr(ctrl, v_rdata0[k], v_rdata1[k], s_rdata0, v_idx, k);
          x_wdata[k]    <= v_rdata1[k];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------

  // One LFSR step per bit taken
  function automatic logic [31:0] draw(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = step_lfsr(lfsr);
    end
    return v;
  endfunction

  function automatic logic pipe_busy();
    logic b;
    b = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      b = b | model_v[i];
    end
    return b;
  endfunction

  // Drive one instruction with random operands, hold it until taken
  task automatic send(input vec_dpath_pkg::vec_ctrl_t c);
    logic [31:0] rnd;
    logic taken;
    int waited;
    issue <= 1'b1;
    ctrl <= c;
    for (int k = 0; k < NUM_LANES; k++) begin
      v_rdata0[k] <= draw(32);
      v_rdata1[k] <= draw(32);
    end
    s_rdata0 <= draw(32);
    rnd = draw(vec_dpath_pkg::IDX_W);
    v_idx <= rnd[vec_dpath_pkg::IDX_W-1:0];
    taken = 1'b0;
    waited = 0;
    while (!taken && !hung) begin
      @(posedge clk);
      taken = !stall;
      stall <= stall_on && (draw(2) == 32'd0);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timeout: instruction not taken within %0d cycles", WAIT_LIMIT);
        hung = 1'b1;
      end
    end
    issued++;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    issue <= 1'b0;
    do begin
      @(posedge clk);
      stall <= stall_on && (draw(2) == 32'd0);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timeout: pipeline still busy after %0d cycles", WAIT_LIMIT);
        hung = 1'b1;
      end
    end while (!hung && (wb_valid || pipe_busy()));
  endtask

  task automatic report(input string name, input int errs_before);
    tests++;
    if (errors + seq_errors == errs_before) begin
      $display("Test %0d, %s: ok", tests, name);
    end else begin
      $display("Test %0d, %s: %0d errors", tests, name, errors + seq_errors - errs_before);
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    int waited;
    int base_err;
    int base_issued;
    int base_results;
    logic [31:0] rnd;
    vec_dpath_pkg::vec_ctrl_t c;

    lfsr = 32'hbb00_a808;
    hung = 1'b0;
    stall_on = 1'b0;
    seq_errors = 0;
    tests = 0;
    issued = 0;
    stall <= 1'b0;
    issue <= 1'b0;
    ctrl <= '0;
    s_rdata0 <= '0;
    v_idx <= '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      v_rdata0[k] <= '0;
      v_rdata1[k] <= '0;
    end

    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (reset && waited < WAIT_LIMIT);
    if (reset) begin
      $display("Timeout: reset was never released");
      hung = 1'b1;
    end

    // Idle pipe stays empty
    base_err = errors + seq_errors;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      assert (wb_valid === 1'b0) else begin
        $display("Error: wb_valid is %h with nothing issued", wb_valid);
        seq_errors++;
      end
    end
    report("idle after reset", base_err);

    base_err = errors + seq_errors;
    for (int f = 0; f <= 10; f++) begin
      for (int n = 0; n < 3; n++) begin
        c = '0;
        c.op0_sel = vec_dpath_pkg::OP0_VEC;
        c.op1_sel = vec_dpath_pkg::OP1_VEC;
        c.alu_fn = vec_dpath_pkg::alu_fn_t'(4'(f));
        send(c);
      end
    end
    drain();
    report("vector ALU functions", base_err);

    base_err = errors + seq_errors;
    for (int n = 0; n < 8; n++) begin
      c = '0;
      c.op0_sel = vec_dpath_pkg::OP0_BCAST;
      c.op1_sel = vec_dpath_pkg::OP1_STRIDE;
      c.alu_fn = vec_dpath_pkg::ADD;
      send(c);
    end
    drain();
    report("broadcast with stride", base_err);

    base_err = errors + seq_errors;
    for (int kind = 0; kind < 5; kind++) begin
      for (int n = 0; n < 3; n++) begin
        c = '0;
        c.op0_sel = vec_dpath_pkg::OP0_VEC;
        c.op1_sel = vec_dpath_pkg::OP1_ZERO;
        c.alu_fn = vec_dpath_pkg::ADD;
        c.load_kind = vec_dpath_pkg::load_kind_t'(3'(kind));
        c.wb_sel = 1'b1;
        send(c);
      end
    end
    drain();
    report("subword loads", base_err);

    // Random mix under random stalls
    base_err = errors + seq_errors;
    base_issued = issued;
    base_results = results;
    stall_on = 1'b1;
    for (int n = 0; n < 48; n++) begin
      rnd = draw(4) % 32'd11;
      c.alu_fn = vec_dpath_pkg::alu_fn_t'(rnd[3:0]);
      rnd = draw(2) % 32'd3;
      c.op0_sel = vec_dpath_pkg::op0_sel_t'(rnd[1:0]);
      rnd = draw(2) % 32'd3;
      c.op1_sel = vec_dpath_pkg::op1_sel_t'(rnd[1:0]);
      rnd = draw(3) % 32'd5;
      c.load_kind = vec_dpath_pkg::load_kind_t'(rnd[2:0]);
      rnd = draw(1);
      c.wb_sel = rnd[0];
      send(c);
    end
    drain();
    stall_on = 1'b0;
    stall <= 1'b0;
    assert (results - base_results == issued - base_issued) else begin
      $display("Results lost or duplicated under stall: %0d issued, %0d written back",
               issued - base_issued, results - base_results);
      seq_errors++;
    end
    report("random stalls", base_err);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors + seq_errors);
    if (errors + seq_errors == 0 && !hung) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+testbench
common/vec_dpath_pkg.sv
verilog/stage_reg.sv
verilog/operand_select.sv
execute/lane_alu.sv
execute/exec_stage.sv
verilog/mem_stage.sv
verilog/vec_dpath.sv
testbench/tb_clock.sv
testbench/tb_vec_dpath.sv

//--- run.sh
#!/bin/sh
# Build and run the vector datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_vec_dpath -o tb_vec_dpath \
  || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_vec_dpath)
echo "$out"
echo "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1
